/* huff_cfg.svh */
`ifndef HUFF_CFG_SVH
`define HUFF_CFG_SVH

// ==============================
// encoder dimensions
// ==============================

// symbols 1 to 6 of the gray stream
`define HUFF_SYMBOLS 6

// counts and node sums, a frame holds at most 255 symbols
`define HUFF_COUNT_W 8

// code and length mask width
`define HUFF_CODE_W 8

// odd-even passes, enough to sort the full list
`define HUFF_SORT_PASSES 6

`endif

/* huff_data_pkg.sv */
`include "huff_cfg.svh"

package huff_data_pkg;

	// ==============================
	// scalar types
	// ==============================

	// occurrence count of a symbol or a merged node
	typedef logic [`HUFF_COUNT_W-1:0] count_t;

	// bit i stands for symbol i+1
	typedef logic [`HUFF_SYMBOLS-1:0] mask_t;

	// code bits, or thermometer length mask
	typedef logic [`HUFF_CODE_W-1:0] code_t;

	// ==============================
	// per-symbol arrays
	// ==============================

	// element i belongs to symbol i+1
	typedef count_t [`HUFF_SYMBOLS-1:0] count_arr_t;

	typedef code_t [`HUFF_SYMBOLS-1:0] code_arr_t;

endpackage

/* huff_ctrl_pkg.sv */
package huff_ctrl_pkg;

	// encoder sequence
	// receive runs while gray_valid is high
	// sort and merge alternate until one node is left
	typedef enum logic [2:0] {
		st_idle,
		st_receive,
		st_count_out,
		st_load,
		st_sort,
		st_merge,
		st_finish
	} huff_state_e;

endpackage

/* symbol_counter.sv */
`timescale 1ns/1ps
`include "huff_cfg.svh"

module symbol_counter (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       gray_valid,
	input  logic [7:0]                 gray_data,
	input  logic                       frame_start,
	output huff_data_pkg::count_arr_t  counts
);
	import huff_data_pkg::*;

	localparam int N = `HUFF_SYMBOLS;

	// high from frame_start until the burst ends
	logic armed;
	logic [N-1:0] bump;

	always_ff @(posedge clk) begin
		if (reset) begin
			armed <= 1'b0;
		end else begin
			armed <= frame_start | (armed & gray_valid);
		end
	end

	// values outside 1..6 match no counter
	always_comb begin
		for (int i = 0; i < N; i++) begin
			bump[i] = gray_valid && (armed || frame_start) && (gray_data == 8'(i + 1));
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			counts <= '0;
		end else begin
			for (int i = 0; i < N; i++) begin
				if (frame_start) begin
					// new frame, old tallies dropped
					counts[i] <= count_t'(bump[i]);
				end else if (bump[i]) begin
					counts[i] <= counts[i] + count_t'(1);
				end
			end
		end
	end

	// frames are limited to 255 symbols, so no tally may roll over
	for (genvar g = 0; g < N; g++) begin : g_wrap_chk
		assert property (@(posedge clk) disable iff (reset)
			(bump[g] && !frame_start) |=> (counts[g] != '0));
	end

endmodule

/* node_sorter.sv */
`timescale 1ns/1ps
`include "huff_cfg.svh"

module node_sorter (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       load,
	input  logic                       sort_step,
	input  logic                       merge,
	input  huff_data_pkg::count_arr_t  counts,
	output huff_data_pkg::mask_t       tail_zero_mask,
	output huff_data_pkg::mask_t       tail_one_mask
);
	import huff_data_pkg::*;

	localparam int N = `HUFF_SYMBOLS;

	// ==============================
	// node list
	// ==============================

	// entry 0 holds the largest count
	count_t cnt [N];
	mask_t  msk [N];

	// list after one transposition pass
	count_t sort_cnt [N];
	mask_t  sort_msk [N];

	// number of live entries, from the head
	logic [2:0] live;

	// 0 compares pairs (0,1) (2,3) (4,5), 1 compares (1,2) (3,4)
	logic parity;

	// true when node a belongs ahead of node b
	// larger count first, smaller mask breaks a tie
	function automatic logic goes_before(
		input count_t ca,
		input mask_t  ma,
		input count_t cb,
		input mask_t  mb
	);
		return (ca > cb) || ((ca == cb) && (ma < mb));
	endfunction

	// ==============================
	// odd-even pass
	// ==============================

	always_comb begin
		sort_cnt = cnt;
		sort_msk = msk;
		for (int j = 0; j < N - 1; j++) begin
			// pairs are disjoint, so each reads the unswapped list
			if (((j % 2) == int'(parity)) && ((j + 2) <= int'(live))
					&& goes_before(cnt[j + 1], msk[j + 1], cnt[j], msk[j])) begin
				sort_cnt[j]     = cnt[j + 1];
				sort_msk[j]     = msk[j + 1];
				sort_cnt[j + 1] = cnt[j];
				sort_msk[j + 1] = msk[j];
			end
		end
	end

	// ==============================
	// list control
	// ==============================

	always_ff @(posedge clk) begin
		if (reset) begin
			live   <= '0;
			parity <= 1'b0;
		end else if (load) begin
			live   <= 3'(N);
			parity <= 1'b0;
		end else if (merge) begin
			live   <= live - 3'd1;
			parity <= 1'b0;
		end else if (sort_step) begin
			parity <= ~parity;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			for (int i = 0; i < N; i++) begin
				cnt[i] <= counts[i];
				msk[i] <= mask_t'(1) << i;
			end
		end else if (merge) begin
			// last two live entries fold into the second-to-last slot
			for (int j = 0; j < N - 1; j++) begin
				if ((j + 2) == int'(live)) begin
					cnt[j]     <= cnt[j] + cnt[j + 1];
					msk[j]     <= msk[j] | msk[j + 1];
					cnt[j + 1] <= '0;
					msk[j + 1] <= '0;
				end
			end
		end else if (sort_step) begin
			cnt <= sort_cnt;
			msk <= sort_msk;
		end
	end

	// ==============================
	// tail of the list
	// ==============================

	// smallest node takes bit 0, its neighbour bit 1
	assign tail_zero_mask = (live >= 3'd2) ? msk[live - 3'd1] : '0;
	assign tail_one_mask  = (live >= 3'd2) ? msk[live - 3'd2] : '0;

	// every merge needs two nodes to join
	assert property (@(posedge clk) disable iff (reset)
		merge |-> (live >= 3'd2));

endmodule

/* code_builder.sv */
`timescale 1ns/1ps
`include "huff_cfg.svh"

module code_builder (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      load,
	input  logic                      merge,
	input  huff_data_pkg::mask_t      tail_zero_mask,
	input  huff_data_pkg::mask_t      tail_one_mask,
	output huff_data_pkg::code_arr_t  codes,
	output huff_data_pkg::code_arr_t  lens
);
	import huff_data_pkg::*;

	localparam int N = `HUFF_SYMBOLS;
	localparam int W = `HUFF_CODE_W;

	// symbols taking a bit at this merge
	mask_t hit;

	// one-hot position of the next code bit per symbol
	code_arr_t next_pos;

	// symbols whose length mask is already full
	logic [N-1:0] full;

	assign hit = tail_zero_mask | tail_one_mask;

	always_comb begin
		for (int i = 0; i < N; i++) begin
			next_pos[i] = {lens[i][W-2:0], 1'b1} & ~lens[i];
			full[i]     = lens[i][W-1];
		end
	end

	// bits arrive leaf first, so each new one lands above the last
	always_ff @(posedge clk) begin
		if (reset) begin
			codes <= '0;
			lens  <= '0;
		end else if (load) begin
			codes <= '0;
			lens  <= '0;
		end else if (merge) begin
			for (int i = 0; i < N; i++) begin
				if (hit[i]) begin
					if (tail_one_mask[i]) begin
						codes[i] <= codes[i] | next_pos[i];
					end
					lens[i] <= {lens[i][W-2:0], 1'b1};
				end
			end
		end
	end

	// a symbol never gets more bits than the code width
	assert property (@(posedge clk) disable iff (reset)
		merge |-> ((hit & full) == '0));

endmodule

/* huff_ctrl.sv */
`timescale 1ns/1ps
`include "huff_cfg.svh"

module huff_ctrl (
	input  logic clk,
	input  logic reset,
	input  logic gray_valid,
	output logic frame_start,
	output logic cnt_valid,
	output logic load,
	output logic sort_step,
	output logic merge,
	output logic code_valid
);
	import huff_ctrl_pkg::*;

	localparam int N      = `HUFF_SYMBOLS;
	localparam int PASSES = `HUFF_SORT_PASSES;

	huff_state_e state;
	huff_state_e state_nxt;

	// sort passes done in the current run
	logic [2:0] pass_cnt;
	// merges done in this frame
	logic [2:0] round_cnt;

	// ==============================
	// state register
	// ==============================

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= st_idle;
			pass_cnt  <= '0;
			round_cnt <= '0;
		end else begin
			state <= state_nxt;
			if (state == st_sort) begin
				pass_cnt <= pass_cnt + 3'd1;
			end else begin
				pass_cnt <= '0;
			end
			if (state == st_load) begin
				round_cnt <= '0;
			end else if (state == st_merge) begin
				round_cnt <= round_cnt + 3'd1;
			end
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle:      if (gray_valid) state_nxt = st_receive;
			st_receive:   if (!gray_valid) state_nxt = st_count_out;
			st_count_out: state_nxt = st_load;
			st_load:      state_nxt = st_sort;
			st_sort:      if (pass_cnt == 3'(PASSES - 1)) state_nxt = st_merge;
			// the last merge leaves the root alone
			st_merge:     state_nxt = (round_cnt == 3'(N - 2)) ? st_finish : st_sort;
			st_finish:    state_nxt = st_idle;
			default:      state_nxt = st_idle;
		endcase
	end

	// ==============================
	// strobes
	// ==============================

	assign frame_start = (state == st_idle) && gray_valid;
	assign cnt_valid   = (state == st_count_out);
	assign load        = (state == st_load);
	assign sort_step   = (state == st_sort);
	assign merge       = (state == st_merge);
	assign code_valid  = (state == st_finish);

	assert property (@(posedge clk) disable iff (reset)
		!(cnt_valid && code_valid));

endmodule

/* huffman_top.sv */
`timescale 1ns/1ps

module huffman_top (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       gray_valid,
	input  logic [7:0]                 gray_data,
	output logic                       cnt_valid,
	output huff_data_pkg::count_arr_t  counts,
	output logic                       code_valid,
	output huff_data_pkg::code_arr_t   codes,
	output huff_data_pkg::code_arr_t   lens
);
	import huff_data_pkg::*;

	// sequencing strobes
	logic frame_start;
	logic load;
	logic sort_step;
	logic merge;

	// ends of the node list
	mask_t tail_zero_mask;
	mask_t tail_one_mask;

	huff_ctrl ctrl_i (
		.clk         (clk),
		.reset       (reset),
		.gray_valid  (gray_valid),
		.frame_start (frame_start),
		.cnt_valid   (cnt_valid),
		.load        (load),
		.sort_step   (sort_step),
		.merge       (merge),
		.code_valid  (code_valid)
	);

	symbol_counter counter_i (
		.clk         (clk),
		.reset       (reset),
		.gray_valid  (gray_valid),
		.gray_data   (gray_data),
		.frame_start (frame_start),
		.counts      (counts)
	);

	node_sorter sorter_i (
		.clk            (clk),
		.reset          (reset),
		.load           (load),
		.sort_step      (sort_step),
		.merge          (merge),
		.counts         (counts),
		.tail_zero_mask (tail_zero_mask),
		.tail_one_mask  (tail_one_mask)
	);

	code_builder builder_i (
		.clk            (clk),
		.reset          (reset),
		.load           (load),
		.merge          (merge),
		.tail_zero_mask (tail_zero_mask),
		.tail_one_mask  (tail_one_mask),
		.codes          (codes),
		.lens           (lens)
	);

endmodule

/* huffman_tb.sv */
`timescale 1ns/1ps
`include "huff_cfg.svh"

module huffman_tb;
	import huff_data_pkg::*;
	import huff_ctrl_pkg::*;

	localparam int N             = `HUFF_SYMBOLS;
	localparam int LATENCY       = 37;
	// negedges from the end of the burst to cnt_valid
	localparam int CNT_DELAY     = 1;
	localparam int CNT_TIMEOUT   = 20;
	localparam int CODE_TIMEOUT  = 100;
	localparam int RANDOM_FRAMES = 20;

	logic       clk;
	logic       reset;
	logic       gray_valid;
	logic [7:0] gray_data;
	logic       cnt_valid;
	logic       code_valid;
	count_arr_t counts;
	code_arr_t  codes;
	code_arr_t  lens;

	// current frame and its expected results
	logic [7:0] frame_q [$];
	count_t     exp_counts [N];
	code_t      exp_codes [N];
	code_t      exp_lens [N];

	int value_errors;
	int timeout_errors;
	int protocol_errors;

	huffman_top dut_i (
		.clk        (clk),
		.reset      (reset),
		.gray_valid (gray_valid),
		.gray_data  (gray_data),
		.cnt_valid  (cnt_valid),
		.counts     (counts),
		.code_valid (code_valid),
		.codes      (codes),
		.lens       (lens)
	);

	always #4 clk = ~clk;

	// ==============================
	// compare tasks
	// ==============================

	task automatic check_count(input string name, input count_t exp, input count_t act);
		if (exp !== act) begin
			$display("** Error: %s expected %0d actual %0d", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_code(input string name, input code_t exp, input code_t act);
		if (exp !== act) begin
			$display("** Error: %s expected %b actual %b", name, exp, act);
			value_errors++;
		end
	endtask

	// ==============================
	// reference model
	// ==============================

	// tallies, then sorted list with five tail merges
	task automatic compute_model();
		int ncnt [N];
		int nmsk [N];
		int len [N];
		int live;
		int tc;
		int tm;
		bit ahead;
		for (int i = 0; i < N; i++) begin
			exp_counts[i] = '0;
			exp_codes[i]  = '0;
			len[i]        = 0;
		end
		foreach (frame_q[b]) begin
			if (frame_q[b] >= 8'd1 && frame_q[b] <= 8'(N)) begin
				exp_counts[frame_q[b] - 1] = exp_counts[frame_q[b] - 1] + count_t'(1);
			end
		end
		for (int i = 0; i < N; i++) begin
			ncnt[i] = int'(exp_counts[i]);
			nmsk[i] = 1 << i;
		end
		live = N;
		while (live > 1) begin
			// count descending, smaller mask ahead on a tie
			for (int p = 0; p < live; p++) begin
				for (int j = 0; j < live - 1; j++) begin
					ahead = (ncnt[j + 1] > ncnt[j])
						|| ((ncnt[j + 1] == ncnt[j]) && (nmsk[j + 1] < nmsk[j]));
					if (ahead) begin
						tc          = ncnt[j];
						tm          = nmsk[j];
						ncnt[j]     = ncnt[j + 1];
						nmsk[j]     = nmsk[j + 1];
						ncnt[j + 1] = tc;
						nmsk[j + 1] = tm;
					end
				end
			end
			// last node gives bit 0, the one before it bit 1
			for (int s = 0; s < N; s++) begin
				if (nmsk[live - 2][s]) begin
					exp_codes[s] = exp_codes[s] | code_t'(1 << len[s]);
				end
				if (nmsk[live - 1][s] || nmsk[live - 2][s]) begin
					len[s]++;
				end
			end
			ncnt[live - 2] = ncnt[live - 2] + ncnt[live - 1];
			nmsk[live - 2] = nmsk[live - 2] | nmsk[live - 1];
			live--;
		end
		for (int s = 0; s < N; s++) begin
			exp_lens[s] = code_t'((1 << len[s]) - 1);
		end
	endtask

	// ==============================
	// frame builders
	// ==============================

	// mostly symbols, a quarter any byte value
	task automatic make_random_frame(input int keep_mask);
		int n;
		int v;
		frame_q.delete();
		n = 1 + int'($urandom % 200);
		repeat (n) begin
			if (($urandom % 4) == 0) begin
				v = int'($urandom % 256);
			end else begin
				v = 1 + int'($urandom % N);
			end
			if (v >= 1 && v <= N && !keep_mask[v - 1]) begin
				v = 7 + int'($urandom % 249);
			end
			frame_q.push_back(8'(v));
		end
	endtask

	task automatic make_equal_frame(input int reps);
		frame_q.delete();
		for (int r = 0; r < reps; r++) begin
			for (int s = 1; s <= N; s++) begin
				frame_q.push_back(8'(s));
			end
			frame_q.push_back(8'd0);
			frame_q.push_back(8'd255);
		end
	endtask

	// ==============================
	// stimulus and waits
	// ==============================

	task automatic send_frame();
		foreach (frame_q[b]) begin
			@(negedge clk);
			gray_valid = 1'b1;
			gray_data  = frame_q[b];
		end
		@(negedge clk);
		gray_valid = 1'b0;
		gray_data  = 8'd0;
	endtask

	task automatic wait_cnt_valid(input string name, output bit seen, output int n);
		huff_state_e st;
		seen = 1'b0;
		n    = 0;
		while (!seen && n < CNT_TIMEOUT) begin
			if (cnt_valid) begin
				seen = 1'b1;
			end else begin
				@(negedge clk);
				n++;
			end
		end
		if (!seen) begin
			st = dut_i.ctrl_i.state;
			$display("%s: cnt_valid never came, controller stuck in %s", name, st.name());
			timeout_errors++;
		end
	endtask

	// counts cycles from cnt_valid and watches the strobe width
	task automatic wait_code_valid(input string name, output bit seen, output int n);
		huff_state_e st;
		seen = 1'b0;
		n    = 0;
		while (!seen && n < CODE_TIMEOUT) begin
			@(negedge clk);
			n++;
			if (n == 1 && cnt_valid) begin
				$display("%s: cnt_valid stayed high for more than one cycle", name);
				protocol_errors++;
			end
			if (code_valid) seen = 1'b1;
		end
		if (!seen) begin
			st = dut_i.ctrl_i.state;
			$display("%s: code_valid never came, controller stuck in %s", name, st.name());
			timeout_errors++;
		end
	endtask

	task automatic run_frame(input string name);
		bit seen;
		int delay;
		int gap;
		compute_model();
		send_frame();
		wait_cnt_valid(name, seen, delay);
		if (!seen) return;
		if (delay != CNT_DELAY) begin
			$display("** Error: %s count delay expected %0d actual %0d",
				name, CNT_DELAY, delay);
			value_errors++;
		end
		for (int i = 0; i < N; i++) begin
			check_count($sformatf("%s count[%0d]", name, i + 1), exp_counts[i], counts[i]);
		end
		wait_code_valid(name, seen, gap);
		if (!seen) return;
		if (gap != LATENCY) begin
			$display("** Error: %s latency expected %0d actual %0d", name, LATENCY, gap);
			value_errors++;
		end
		for (int i = 0; i < N; i++) begin
			check_code($sformatf("%s code[%0d]", name, i + 1), exp_codes[i], codes[i]);
			check_code($sformatf("%s len[%0d]", name, i + 1), exp_lens[i], lens[i]);
		end
		@(negedge clk);
		if (code_valid) begin
			$display("%s: code_valid stayed high for more than one cycle", name);
			protocol_errors++;
		end
	endtask

	// ==============================
	// main sequence
	// ==============================

	initial begin
		clk             = 1'b0;
		reset           = 1'b1;
		gray_valid      = 1'b0;
		gray_data       = 8'd0;
		value_errors    = 0;
		timeout_errors  = 0;
		protocol_errors = 0;
		void'($urandom(5876));

		repeat (4) @(negedge clk);
		reset = 1'b0;

		// quiet outputs before any frame
		repeat (10) begin
			@(negedge clk);
			if (cnt_valid || code_valid) begin
				$display("a strobe went high with no frame sent");
				protocol_errors++;
			end
		end
		for (int i = 0; i < N; i++) begin
			check_count($sformatf("idle count[%0d]", i + 1), '0, counts[i]);
			check_code($sformatf("idle code[%0d]", i + 1), '0, codes[i]);
			check_code($sformatf("idle len[%0d]", i + 1), '0, lens[i]);
		end

		for (int f = 0; f < RANDOM_FRAMES; f++) begin
			make_random_frame('1);
			run_frame($sformatf("random frame %0d", f));
		end

		// zero counts and ties
		make_equal_frame(5);
		run_frame("equal counts");
		make_equal_frame(1);
		run_frame("equal counts single");
		make_random_frame(6'b010010);
		run_frame("symbols 2 and 5 only");
		make_random_frame(6'b001000);
		run_frame("symbol 4 only");
		make_random_frame(6'b000000);
		run_frame("no symbols");
		for (int f = 0; f < 5; f++) begin
			make_random_frame(int'($urandom % 64));
			run_frame($sformatf("sparse frame %0d", f));
		end

		// a frame after some idle time
		repeat (7) @(negedge clk);
		make_random_frame('1);
		run_frame("after idle gap");

		$display("errors: %0d value, %0d timeout, %0d protocol",
			value_errors, timeout_errors, protocol_errors);
		if (value_errors + timeout_errors + protocol_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* compile.f */
+incdir+.
huff_data_pkg.sv
huff_ctrl_pkg.sv
symbol_counter.sv
node_sorter.sv
code_builder.sv
huff_ctrl.sv
huffman_top.sv
huffman_tb.sv

/* run.sh */
#!/bin/sh
# build and run the Huffman encoder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module huffman_tb -o huffman_sim

./obj_dir/huffman_sim > sim.log 2>&1
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"
